//--- hdl/common.sv
package common;

    // datapath and register index widths
    localparam int xlen          = 32;
    localparam int reg_addr_bits = 5;

    // ALU operation select
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        SLT  = 4'd8,
        SLTU = 4'd9
    } alu_op_type;

    // instruction format from decode
    typedef enum logic [2:0] {
        R_TYPE = 3'd0,
        I_TYPE = 3'd1,
        S_TYPE = 3'd2,
        B_TYPE = 3'd3,
        U_TYPE = 3'd4,
        J_TYPE = 3'd5
    } encoding_type;

    // operand source, none means register file value
    typedef enum logic [1:0] {
        Forward_none     = 2'd0,
        Forward_from_ex  = 2'd1,
        Forward_from_mem = 2'd2
    } forward_type;

    typedef struct packed {
        alu_op_type   alu_op;
        encoding_type encoding;
        logic         alu_src;
        logic         is_branch;
        logic         mem_read;
        logic         mem_write;
        logic         reg_write;
    } control_type;

    // decoded bundle entering execute
    typedef struct packed {
        logic [xlen-1:0]          data1;
        logic [xlen-1:0]          data2;
        logic [xlen-1:0]          immediate_data;
        logic [xlen-1:0]          pc;
        control_type              control;
        logic [reg_addr_bits-1:0] rs1;
        logic [reg_addr_bits-1:0] rs2;
        logic [reg_addr_bits-1:0] rd;
    } id_ex_type;

    typedef struct packed {
        control_type              control;
        logic [xlen-1:0]          alu_data;
        logic [xlen-1:0]          memory_data;
        logic [xlen-1:0]          pc;
        logic [reg_addr_bits-1:0] rd;
    } ex_mem_type;

    typedef struct packed {
        control_type              control;
        logic [xlen-1:0]          result;
        logic [reg_addr_bits-1:0] rd;
    } mem_wb_type;

    // fetch redirect, b-type taken or jalr target
    typedef struct packed {
        logic            pc_src;
        logic            jalr_flag;
        logic [xlen-1:0] jalr_target;
    } redirect_type;

endpackage

//--- hdl/alu.sv
`timescale 1ns/1ns

module alu import common::*; (
    input  alu_op_type      control,
    input  logic [xlen-1:0] left_operand,
    input  logic [xlen-1:0] right_operand,
    output logic [xlen-1:0] result,
    output logic            zero_flag,
    output logic            overflow
);

    logic [xlen-1:0] sum;
    logic [xlen-1:0] difference;
    logic [4:0]      shamt;
    logic            add_overflow;
    logic            sub_overflow;

    assign sum        = left_operand + right_operand;
    assign difference = left_operand - right_operand;
    assign shamt      = right_operand[4:0];

    // same-sign inputs giving a flipped sign
    assign add_overflow = (left_operand[xlen-1] == right_operand[xlen-1]) &&
                          (sum[xlen-1] != left_operand[xlen-1]);
    // opposite-sign inputs, result sign differs from minuend
    assign sub_overflow = (left_operand[xlen-1] != right_operand[xlen-1]) &&
                          (difference[xlen-1] != left_operand[xlen-1]);

    always_comb begin
        case (control)
            ADD:     result = sum;
            SUB:     result = difference;
            AND:     result = left_operand & right_operand;
            OR:      result = left_operand | right_operand;
            XOR:     result = left_operand ^ right_operand;
            SLL:     result = left_operand << shamt;
            SRL:     result = left_operand >> shamt;
            SRA:     result = $unsigned($signed(left_operand) >>> shamt);
            SLT:     result = {{(xlen-1){1'b0}}, $signed(left_operand) < $signed(right_operand)};
            SLTU:    result = {{(xlen-1){1'b0}}, left_operand < right_operand};
            default: result = '0;
        endcase
    end

    always_comb begin
        case (control)
            ADD:     overflow = add_overflow;
            SUB:     overflow = sub_overflow;
            default: overflow = 1'b0;
        endcase
    end

    assign zero_flag = (result == '0);

endmodule

//--- hdl/forwarding_unit.sv
`timescale 1ns/1ns

module forwarding_unit import common::*; (
    input  logic [reg_addr_bits-1:0] rs1,
    input  logic [reg_addr_bits-1:0] rs2,
    input  ex_mem_type               ex_mem,
    input  logic                     ex_mem_valid,
    input  mem_wb_type               mem_wb,
    input  logic                     mem_wb_valid,
    output forward_type              forward_rs1,
    output forward_type              forward_rs2
);

    logic ex_writes;
    logic wb_writes;

    // x0 is hardwired, never a forward source
    assign ex_writes = ex_mem_valid && ex_mem.control.reg_write && (ex_mem.rd != '0);
    assign wb_writes = mem_wb_valid && mem_wb.control.reg_write && (mem_wb.rd != '0);

    // younger instruction in EX/MEM wins over MEM/WB
    function automatic forward_type pick_source(
        input logic [reg_addr_bits-1:0] src,
        input logic                     ex_ok,
        input logic [reg_addr_bits-1:0] ex_rd,
        input logic                     wb_ok,
        input logic [reg_addr_bits-1:0] wb_rd
    );
        if (ex_ok && ex_rd == src)
            return Forward_from_ex;
        else if (wb_ok && wb_rd == src)
            return Forward_from_mem;
        else
            return Forward_none;
    endfunction

    assign forward_rs1 = pick_source(rs1, ex_writes, ex_mem.rd, wb_writes, mem_wb.rd);
    assign forward_rs2 = pick_source(rs2, ex_writes, ex_mem.rd, wb_writes, mem_wb.rd);

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import common::*; (
    input  id_ex_type       id_ex,
    input  forward_type     forward_rs1,
    input  forward_type     forward_rs2,
    input  logic [xlen-1:0] mem_forward_data,
    input  logic [xlen-1:0] wb_forward_data,
    output ex_mem_type      ex_result,
    output redirect_type    redirect,
    output logic            overflow
);

    control_type     ctrl;
    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
    logic [xlen-1:0] left_operand;
    logic [xlen-1:0] right_operand;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] link_value;
    logic            zero_flag;
    logic            is_jalr;
    logic            is_jal;

    function automatic logic [xlen-1:0] select_operand(
        input forward_type     fwd,
        input logic [xlen-1:0] reg_value,
        input logic [xlen-1:0] ex_value,
        input logic [xlen-1:0] wb_value
    );
        case (fwd)
            Forward_from_ex:  return ex_value;
            Forward_from_mem: return wb_value;
            default:          return reg_value;
        endcase
    endfunction

    assign ctrl = id_ex.control;

    // forward first, so the immediate select sits after it
    assign rs1_value = select_operand(forward_rs1, id_ex.data1, mem_forward_data, wb_forward_data);
    assign rs2_value = select_operand(forward_rs2, id_ex.data2, mem_forward_data, wb_forward_data);

    assign left_operand  = rs1_value;
    assign right_operand = ctrl.alu_src ? id_ex.immediate_data : rs2_value;

    alu u_alu (
        .control       (ctrl.alu_op),
        .left_operand  (left_operand),
        .right_operand (right_operand),
        .result        (alu_result),
        .zero_flag     (zero_flag),
        .overflow      (overflow)
    );

    // jalr is decoded as i-type with the branch bit
    assign is_jalr    = (ctrl.encoding == I_TYPE) && ctrl.is_branch;
    assign is_jal     = (ctrl.encoding == J_TYPE);
    assign link_value = id_ex.pc + xlen'(4);

    always_comb begin
        redirect = '0;
        if (is_jalr) begin
            redirect.jalr_flag   = 1'b1;
            redirect.jalr_target = left_operand + id_ex.immediate_data;
        end else if (ctrl.encoding == B_TYPE) begin
            // beq via SUB, taken when operands match
            redirect.pc_src = zero_flag;
        end
    end

    always_comb begin
        ex_result.control     = ctrl;
        ex_result.alu_data    = (is_jalr || is_jal) ? link_value : alu_result;
        ex_result.memory_data = rs2_value;
        ex_result.pc          = id_ex.pc;
        ex_result.rd          = id_ex.rd;
    end

endmodule

//--- hdl/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // bubbles load as zero so control fields stay clean
    always_ff @(posedge clk) begin
        if (rst || !in_valid) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= 1'b1;
            out_data  <= in_data;
        end
    end

endmodule

//--- hdl/execute_path.sv
`timescale 1ns/1ns

module execute_path import common::*; (
    input  logic         clk,
    input  logic         rst,
    input  id_ex_type    id_ex,
    input  logic         id_ex_valid,
    output ex_mem_type   ex_mem,
    output logic         ex_mem_valid,
    output mem_wb_type   mem_wb,
    output logic         mem_wb_valid,
    output redirect_type redirect,
    output logic         overflow
);

    forward_type  forward_rs1;
    forward_type  forward_rs2;
    ex_mem_type   ex_result;
    redirect_type stage_redirect;
    mem_wb_type   wb_next;

    forwarding_unit u_forwarding_unit (
        .rs1          (id_ex.rs1),
        .rs2          (id_ex.rs2),
        .ex_mem       (ex_mem),
        .ex_mem_valid (ex_mem_valid),
        .mem_wb       (mem_wb),
        .mem_wb_valid (mem_wb_valid),
        .forward_rs1  (forward_rs1),
        .forward_rs2  (forward_rs2)
    );

    execute_stage u_execute_stage (
        .id_ex            (id_ex),
        .forward_rs1      (forward_rs1),
        .forward_rs2      (forward_rs2),
        .mem_forward_data (ex_mem.alu_data),
        .wb_forward_data  (mem_wb.result),
        .ex_result        (ex_result),
        .redirect         (stage_redirect),
        .overflow         (overflow)
    );

    // no redirect out of an empty slot
    assign redirect = id_ex_valid ? stage_redirect : '0;

    pipe_reg #(.payload_t(ex_mem_type)) ex_mem_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (id_ex_valid),
        .in_data   (ex_result),
        .out_valid (ex_mem_valid),
        .out_data  (ex_mem)
    );

    // no data memory, result is the alu value
    assign wb_next = '{control: ex_mem.control, result: ex_mem.alu_data, rd: ex_mem.rd};

    pipe_reg #(.payload_t(mem_wb_type)) mem_wb_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (ex_mem_valid),
        .in_data   (wb_next),
        .out_valid (mem_wb_valid),
        .out_data  (mem_wb)
    );

endmodule

//--- tb/execute_path_checker.sv
`timescale 1ns/1ns

module execute_path_checker import common::*; (
    input logic         clk,
    input logic         rst,
    input logic         id_ex_valid,
    input ex_mem_type   ex_mem,
    input logic         ex_mem_valid,
    input logic         mem_wb_valid,
    input redirect_type redirect
);

    // count of failed assertions, polled by the testbench
    int unsigned failures = 0;

    // registers clear on every edge that sees reset
    reset_clears_valid: assert property (@(posedge clk) rst |=> !ex_mem_valid && !mem_wb_valid)
        else begin
            failures++;
            $error("valid output high after a reset cycle");
        end

    // mem_wb still empty one cycle after reset release
    release_keeps_wb_empty: assert property (@(posedge clk) $fell(rst) |=> !mem_wb_valid)
        else begin
            failures++;
            $error("mem_wb_valid high right after reset release");
        end

    // jalr never takes the branch and its link value lands in ex_mem next cycle
    jalr_excludes_branch: assert property (@(posedge clk) disable iff (rst)
        redirect.jalr_flag |-> !redirect.pc_src ##1
            (ex_mem_valid && ex_mem.alu_data == ex_mem.pc + 32'd4))
        else begin
            failures++;
            $error("jalr_flag with pc_src set or jalr link missing from ex_mem");
        end

    valid_follows_input: assert property (
        @(posedge clk) !rst |=> (ex_mem_valid == $past(id_ex_valid)))
        else begin
            failures++;
            $error("ex_mem_valid does not follow id_ex_valid");
        end

endmodule

bind execute_path execute_path_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .id_ex_valid  (id_ex_valid),
    .ex_mem       (ex_mem),
    .ex_mem_valid (ex_mem_valid),
    .mem_wb_valid (mem_wb_valid),
    .redirect     (redirect)
);

//--- tb/tb_execute_path.sv
`timescale 1ns/1ns

module tb_execute_path import common::*; ();

    localparam int reset_cycles   = 8;
    localparam int num_slots      = 400;
    localparam int timeout_cycles = reset_cycles + num_slots + 50;

    typedef struct packed {
        ex_mem_type   ex;
        redirect_type redirect;
        logic         overflow;
    } expect_type;

    logic         clk = 1'b0;
    logic         rst;
    id_ex_type    id_ex;
    logic         id_ex_valid;
    ex_mem_type   ex_mem;
    logic         ex_mem_valid;
    mem_wb_type   mem_wb;
    logic         mem_wb_valid;
    redirect_type redirect;
    logic         overflow;

    logic [31:0]  lfsr = 32'h6d14_d61b;
    int           cycle_count = 0;
    int           done_count = 0;
    logic         slot_live;
    logic         ex_live = 1'b0;
    logic         wb_live = 1'b0;

    // model of what the two pipeline registers hold now
    ex_mem_type   exp_ex_mem = '0;
    logic         exp_ex_valid = 1'b0;
    mem_wb_type   exp_mem_wb = '0;
    logic         exp_wb_valid = 1'b0;

    execute_path dut (
        .clk          (clk),
        .rst          (rst),
        .id_ex        (id_ex),
        .id_ex_valid  (id_ex_valid),
        .ex_mem       (ex_mem),
        .ex_mem_valid (ex_mem_valid),
        .mem_wb       (mem_wb),
        .mem_wb_valid (mem_wb_valid),
        .redirect     (redirect),
        .overflow     (overflow)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // small values, values near signed max, or full random
    task automatic pick_data(output logic [31:0] value);
        logic [31:0] mode;
        logic [31:0] raw;
        take_bits(2, mode);
        case (mode[1:0])
            2'd0:    take_bits(3, value);
            2'd1: begin
                take_bits(4, raw);
                value = 32'h7fff_fff8 + raw;
            end
            default: take_bits(32, value);
        endcase
    endtask

    task automatic make_instruction(output id_ex_type ins, output logic valid);
        logic [31:0] r;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] imm;
        control_type c;
        take_bits(3, r);
        valid = (r[2:0] != 3'd0);
        pick_data(d1);
        pick_data(d2);
        pick_data(imm);
        c = '0;
        take_bits(4, r);
        c.alu_op = alu_op_type'(r[3:0] % 4'd10);
        take_bits(3, r);
        case (r % 7)
            0: begin
                c.encoding  = R_TYPE;
                c.reg_write = 1'b1;
            end
            1: begin
                c.encoding  = I_TYPE;
                c.alu_src   = 1'b1;
                c.reg_write = 1'b1;
            end
            2: begin
                c = '{ADD, I_TYPE, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
            end
            3: begin
                c = '{ADD, S_TYPE, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
            end
            4: begin
                c = '{SUB, B_TYPE, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
                take_bits(1, r);
                if (r[0])
                    d2 = d1;
            end
            5: begin
                c = '{ADD, J_TYPE, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1};
            end
            default: begin
                c = '{ADD, I_TYPE, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
            end
        endcase
        ins = '0;
        ins.data1          = d1;
        ins.data2          = d2;
        ins.immediate_data = imm;
        ins.control        = c;
        take_bits(30, r);
        ins.pc = {r[29:0], 2'b00};
        // indices 0..3 keep hazards frequent
        take_bits(2, r);
        ins.rs1 = r[1:0];
        take_bits(2, r);
        ins.rs2 = r[1:0];
        take_bits(2, r);
        ins.rd = r[1:0];
    endtask

    function automatic logic [31:0] expected_alu(input alu_op_type op, input logic [31:0] a,
                                                 input logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return $unsigned($signed(a) >>> b[4:0]);
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (a < b) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    // exact 64-bit result out of the 32-bit signed range
    function automatic logic signed_overflow(input alu_op_type op, input logic [31:0] a,
                                             input logic [31:0] b);
        longint full;
        case (op)
            ADD:     full = longint'($signed(a)) + longint'($signed(b));
            SUB:     full = longint'($signed(a)) - longint'($signed(b));
            default: return 1'b0;
        endcase
        return (full > 64'sd2147483647) || (full < -64'sd2147483648);
    endfunction

    function automatic logic [31:0] forwarded_value(input logic [4:0] src,
                                                    input logic [31:0] reg_value,
                                                    input ex_mem_type older_ex,
                                                    input logic older_ex_valid,
                                                    input mem_wb_type older_wb,
                                                    input logic older_wb_valid);
        if (src != 5'd0 && older_ex_valid && older_ex.control.reg_write && older_ex.rd == src)
            return older_ex.alu_data;
        if (src != 5'd0 && older_wb_valid && older_wb.control.reg_write && older_wb.rd == src)
            return older_wb.result;
        return reg_value;
    endfunction

    function automatic expect_type predict_execute(input id_ex_type ins,
                                                   input ex_mem_type older_ex,
                                                   input logic older_ex_valid,
                                                   input mem_wb_type older_wb,
                                                   input logic older_wb_valid);
        expect_type  e;
        logic [31:0] a;
        logic [31:0] b_reg;
        logic [31:0] b;
        logic        jalr;
        e     = '0;
        a     = forwarded_value(ins.rs1, ins.data1, older_ex, older_ex_valid,
                                older_wb, older_wb_valid);
        b_reg = forwarded_value(ins.rs2, ins.data2, older_ex, older_ex_valid,
                                older_wb, older_wb_valid);
        b     = ins.control.alu_src ? ins.immediate_data : b_reg;
        jalr  = (ins.control.encoding == I_TYPE) && ins.control.is_branch;
        e.ex.control     = ins.control;
        e.ex.memory_data = b_reg;
        e.ex.pc          = ins.pc;
        e.ex.rd          = ins.rd;
        if (jalr || ins.control.encoding == J_TYPE)
            e.ex.alu_data = ins.pc + 32'd4;
        else
            e.ex.alu_data = expected_alu(ins.control.alu_op, a, b);
        e.overflow = signed_overflow(ins.control.alu_op, a, b);
        if (jalr) begin
            e.redirect.jalr_flag   = 1'b1;
            e.redirect.jalr_target = a + ins.immediate_data;
        end else if (ins.control.encoding == B_TYPE) begin
            e.redirect.pc_src = (a == b);
        end
        return e;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_ex_mem(input ex_mem_type got, input ex_mem_type exp, input string what);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                                     $time, what, exp, got));
    endtask

    task automatic check_mem_wb(input mem_wb_type got, input mem_wb_type exp, input string what);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                                     $time, what, exp, got));
    endtask

    task automatic check_redirect(input redirect_type got, input redirect_type exp,
                                  input string what);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                                     $time, what, exp, got));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED at %0t: %s expected %b got %b",
                                     $time, what, exp, got));
    endtask

    // sample mid-cycle and advance the model as the next edge will
    always @(negedge clk) begin
        expect_type e;
        if (dut.u_checker.failures != 0)
            report_failure("an assertion in the bound execute_path checker failed");
        check_ex_mem(ex_mem, exp_ex_mem, "ex_mem");
        check_flag(ex_mem_valid, exp_ex_valid, "ex_mem_valid");
        check_mem_wb(mem_wb, exp_mem_wb, "mem_wb");
        check_flag(mem_wb_valid, exp_wb_valid, "mem_wb_valid");
        e = predict_execute(id_ex, exp_ex_mem, exp_ex_valid, exp_mem_wb, exp_wb_valid);
        check_redirect(redirect, id_ex_valid ? e.redirect : '0, "redirect");
        if (id_ex_valid)
            check_flag(overflow, e.overflow, "overflow");
        if (wb_live)
            done_count++;
        if (rst) begin
            exp_ex_mem   = '0;
            exp_ex_valid = 1'b0;
            exp_mem_wb   = '0;
            exp_wb_valid = 1'b0;
            ex_live      = 1'b0;
            wb_live      = 1'b0;
        end else begin
            exp_mem_wb.control = exp_ex_mem.control;
            exp_mem_wb.result  = exp_ex_mem.alu_data;
            exp_mem_wb.rd      = exp_ex_mem.rd;
            exp_wb_valid       = exp_ex_valid;
            exp_ex_mem         = id_ex_valid ? e.ex : '0;
            exp_ex_valid       = id_ex_valid;
            wb_live            = ex_live;
            ex_live            = slot_live;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
            report_failure("timeout: pipeline did not drain all test slots in time");
    end

    initial begin
        id_ex_type next_ins;
        logic      next_valid;
        rst         = 1'b1;
        id_ex       = '0;
        id_ex_valid = 1'b0;
        slot_live   = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < num_slots; i++) begin
            make_instruction(next_ins, next_valid);
            @(posedge clk);
            id_ex       <= next_ins;
            id_ex_valid <= next_valid;
            slot_live   <= 1'b1;
        end
        @(posedge clk);
        id_ex       <= '0;
        id_ex_valid <= 1'b0;
        slot_live   <= 1'b0;
        while (done_count < num_slots)
            @(posedge clk);
        if (dut.u_checker.failures == 0) begin
            $display("TEST PASSED");
        end else begin
            report_failure("an assertion in the bound execute_path checker failed");
        end
        $finish;
    end

endmodule

//--- execute_path.f
hdl/common.sv
hdl/alu.sv
hdl/forwarding_unit.sv
hdl/execute_stage.sv
hdl/pipe_reg.sv
hdl/execute_path.sv
tb/execute_path_checker.sv
tb/tb_execute_path.sv
